// ==== Makefile ====
VERILATOR = verilator
FLAGS     = --binary --assert -j 0
TOP       = tb_tiny_rv
FILELIST  = tiny_rv.f
OBJ_DIR   = obj_dir
RUN_ARGS  = +verilator+error+limit+100
PASS_MSG  = === PASS ===

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# the run fails unless the pass message shows up in the output
run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP) $(RUN_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF -- "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== source/apb_debug_port.sv ====
`timescale 1ns/100ps

module apb_debug_port
   import rv_isa_pkg::*;
   import apb_map_pkg::*;
   #(
   parameter int IMEM_DEPTH = 64
   )
   (
   input  logic                          clk,
   input  logic                          rst,
   input  logic                          psel,
   input  logic                          penable,
   input  logic                          pwrite,
   input  logic [apb_addr_w-1:0]         paddr,
   input  logic [xlen-1:0]               pwdata,
   output logic [xlen-1:0]               prdata,
   output logic                          pready,
   output logic                          pslverr,
   output logic                          run,
   output logic                          imem_we,
   output logic [$clog2(IMEM_DEPTH)-1:0] imem_idx,
   output logic [xlen-1:0]               imem_wdata,
   output logic [reg_idx_w-1:0]          dbg_idx,
   input  logic [xlen-1:0]               dbg_data,
   input  logic [xlen-1:0]               pc,
   input  logic                          halted,
   input  logic                          illegal
   );

   localparam int idx_w    = $clog2(IMEM_DEPTH);
   localparam int reg_end  = int'(reg_base) + 4 * (1 << reg_idx_w);
   localparam int imem_end = int'(imem_base) + 4 * IMEM_DEPTH;

   logic            setup;
   logic            access;
   logic            aligned;
   logic            hit_ctrl;
   logic            hit_status;
   logic            hit_pc;
   logic            hit_reg;
   logic            hit_imem;
   logic            unmapped;
   logic            rd_err;
   logic            wr_err;
   logic [xlen-1:0] rd_word;
   logic [xlen-1:0] prdata_q;
   logic            pslverr_q;

   assign setup  = psel & ~penable;
   assign access = psel & penable;

   // misaligned addresses count as unmapped
   assign aligned    = (paddr[1:0] == 2'b00);
   assign hit_ctrl   = (paddr == addr_ctrl);
   assign hit_status = (paddr == addr_status);
   assign hit_pc     = (paddr == addr_pc);
   assign hit_reg    = aligned && int'(paddr) >= int'(reg_base) && int'(paddr) < reg_end;
   assign hit_imem   = aligned && int'(paddr) >= int'(imem_base) && int'(paddr) < imem_end;
   assign unmapped   = ~(hit_ctrl | hit_status | hit_pc | hit_reg | hit_imem);

   assign rd_err = hit_imem | unmapped;
   assign wr_err = hit_status | hit_pc | hit_reg | unmapped | (hit_imem & run);

   assign dbg_idx    = paddr[reg_idx_w+1:2];
   assign imem_idx   = paddr[idx_w+1:2];
   assign imem_wdata = pwdata;
   assign imem_we    = access & pwrite & hit_imem & ~wr_err;

   always_comb begin
      rd_word = '0;
      if (hit_ctrl) rd_word[ctrl_run_bit] = run;
      if (hit_status) begin
         rd_word[status_halt_bit]    = halted;
         rd_word[status_illegal_bit] = illegal;
      end
      if (hit_pc) rd_word = pc;
      if (hit_reg) rd_word = dbg_data;
   end

   // read data and error are captured at the end of setup
   always_ff @(posedge clk) begin
      if (rst) begin
         run       <= 1'b0;
         prdata_q  <= '0;
         pslverr_q <= 1'b0;
      end else begin
         if (setup) begin
            prdata_q  <= (pwrite || rd_err) ? '0 : rd_word;
            pslverr_q <= pwrite ? wr_err : rd_err;
         end else begin
            pslverr_q <= 1'b0;
         end
         if (access && pwrite && hit_ctrl) run <= pwdata[ctrl_run_bit];
      end
   end

   assign prdata  = prdata_q;
   assign pslverr = pslverr_q;
   // no wait states
   assign pready  = 1'b1;

endmodule

// ==== source/apb_map_pkg.sv ====
package apb_map_pkg;

   // byte address width of the debug port
   localparam int apb_addr_w = 12;

   // register map
   localparam logic [apb_addr_w-1:0] addr_ctrl   = 12'h000;
   localparam logic [apb_addr_w-1:0] addr_status = 12'h004;
   localparam logic [apb_addr_w-1:0] addr_pc     = 12'h008;

   // x0..x31, one word each, read only
   localparam logic [apb_addr_w-1:0] reg_base  = 12'h080;

   // instruction words, write only
   localparam logic [apb_addr_w-1:0] imem_base = 12'h400;

   // ctrl bits
   localparam int ctrl_run_bit = 0;

   // status bits
   localparam int status_halt_bit    = 0;
   localparam int status_illegal_bit = 1;

endpackage

// ==== source/decode_if.sv ====
`timescale 1ns/100ps

interface decode_if
   import rv_isa_pkg::*;
   ();

   instr_kind_e          kind;
   logic [reg_idx_w-1:0] rd;
   logic [reg_idx_w-1:0] rs1;
   logic [reg_idx_w-1:0] rs2;
   // sign-extended immediate
   logic [xlen-1:0]      imm;

   modport dec_out (output kind, output rd, output rs1, output rs2, output imm);

   modport core_in (input kind, input rd, input rs1, input rs2, input imm);

endinterface

// ==== source/decoder.sv ====
`timescale 1ns/100ps

module decoder
   import rv_isa_pkg::*;
   (
   input  logic [xlen-1:0] instr_raw,
   decode_if.dec_out       dec
   );

   opcode_e              opcode;
   logic [funct3_w-1:0]  funct3;
   logic [funct7_w-1:0]  funct7;
   logic [xlen-1:0]      imm_i;
   logic [xlen-1:0]      imm_b;
   logic [xlen-1:0]      imm_u;
   logic [xlen-1:0]      imm_j;
   instr_kind_e          kind;
   logic [reg_idx_w-1:0] rd;
   logic [reg_idx_w-1:0] rs1;
   logic [reg_idx_w-1:0] rs2;
   logic [xlen-1:0]      imm;

   assign opcode = opcode_e'(instr_raw[opcode_w-1:0]);
   assign funct3 = instr_raw[14:12];
   assign funct7 = instr_raw[31:25];

   // immediates for the i, b, u and j formats
   assign imm_i = {{20{instr_raw[31]}}, instr_raw[31:20]};
   assign imm_b = {{19{instr_raw[31]}}, instr_raw[31], instr_raw[7],
                   instr_raw[30:25], instr_raw[11:8], 1'b0};
   assign imm_u = {instr_raw[31:12], 12'b0};
   assign imm_j = {{11{instr_raw[31]}}, instr_raw[31], instr_raw[19:12],
                   instr_raw[20], instr_raw[30:21], 1'b0};

   // classify by opcode, funct3 and funct7
   always_comb begin
      kind = k_illegal;
      case (opcode)
         op_imm: if (funct3 == f3_add_sub) kind = k_addi;
         op_reg: begin
            if (funct3 == f3_add_sub && funct7 == f7_base) kind = k_add;
            else if (funct3 == f3_add_sub && funct7 == f7_sub) kind = k_sub;
         end
         lui:    kind = k_lui;
         branch: begin
            if (funct3 == f3_beq) kind = k_beq;
            else if (funct3 == f3_bne) kind = k_bne;
         end
         jal:    kind = k_jal;
         default: kind = k_illegal;
      endcase
   end

   // only the fields that the format uses pass through
   always_comb begin
      rd  = '0;
      rs1 = '0;
      rs2 = '0;
      imm = '0;
      case (kind)
         k_addi: begin
            rd  = instr_raw[11:7];
            rs1 = instr_raw[19:15];
            imm = imm_i;
         end
         k_add, k_sub: begin
            rd  = instr_raw[11:7];
            rs1 = instr_raw[19:15];
            rs2 = instr_raw[24:20];
         end
         k_lui: begin
            rd  = instr_raw[11:7];
            imm = imm_u;
         end
         k_beq, k_bne: begin
            rs1 = instr_raw[19:15];
            rs2 = instr_raw[24:20];
            imm = imm_b;
         end
         k_jal: begin
            rd  = instr_raw[11:7];
            imm = imm_j;
         end
         default: ;
      endcase
   end

   assign dec.kind = kind;
   assign dec.rd   = rd;
   assign dec.rs1  = rs1;
   assign dec.rs2  = rs2;
   assign dec.imm  = imm;

endmodule

// ==== source/reg_file.sv ====
`timescale 1ns/100ps

module reg_file
   import rv_isa_pkg::*;
   (
   input  logic                 clk,
   input  logic                 rst,
   input  logic [reg_idx_w-1:0] rs1,
   input  logic [reg_idx_w-1:0] rs2,
   output logic [xlen-1:0]      rdata1,
   output logic [xlen-1:0]      rdata2,
   input  logic                 we,
   input  logic [reg_idx_w-1:0] waddr,
   input  logic [xlen-1:0]      wdata,
   input  logic [reg_idx_w-1:0] dbg_idx,
   output logic [xlen-1:0]      dbg_data
   );

   // x0 has no storage
   logic [xlen-1:0] regs [1:(1 << reg_idx_w) - 1];

   function automatic logic [xlen-1:0] read_reg(input logic [reg_idx_w-1:0] idx);
      logic [xlen-1:0] val;
      val = '0;
      if (idx != '0) val = regs[idx];
      return val;
   endfunction

   // no writes while reset is held
   always_ff @(posedge clk) begin
      if (!rst && we && waddr != '0) begin
         regs[waddr] <= wdata;
      end
   end

   assign rdata1   = read_reg(rs1);
   assign rdata2   = read_reg(rs2);
   assign dbg_data = read_reg(dbg_idx);

endmodule

// ==== source/rv_core.sv ====
`timescale 1ns/100ps

module rv_core
   import rv_isa_pkg::*;
   #(
   parameter int IMEM_DEPTH = 64
   )
   (
   input  logic                          clk,
   input  logic                          rst,
   input  logic                          run,
   input  logic                          imem_we,
   input  logic [$clog2(IMEM_DEPTH)-1:0] imem_idx,
   input  logic [xlen-1:0]               imem_wdata,
   input  logic [reg_idx_w-1:0]          dbg_idx,
   output logic [xlen-1:0]               dbg_data,
   output logic [xlen-1:0]               pc,
   output logic                          halted,
   output logic                          illegal,
   output logic [xlen-1:0]               instr_raw,
   decode_if.core_in                     dec
   );

   localparam int idx_w = $clog2(IMEM_DEPTH);

   logic [xlen-1:0] imem [IMEM_DEPTH];
   logic [xlen-1:0] pc_q;
   logic            run_q;
   logic            halted_q;
   logic            illegal_q;
   logic            start;
   logic            exec;
   logic [xlen-1:0] pc_cur;
   logic [xlen-1:0] pc_plus4;
   logic [xlen-1:0] next_pc;
   logic [xlen-1:0] rs1_val;
   logic [xlen-1:0] rs2_val;
   logic [xlen-1:0] result;
   logic            take;
   logic            wr_en;
   logic            stop;

   always_ff @(posedge clk) begin
      if (imem_we) imem[imem_idx] <= imem_wdata;
   end

   // first cycle after run rises behaves as pc 0 with flags clear
   assign start   = run & ~run_q;
   assign pc_cur  = start ? '0 : pc_q;
   assign halted  = halted_q & ~start;
   assign illegal = illegal_q & ~start;
   assign pc      = pc_cur;
   assign exec    = run & ~halted;

   assign instr_raw = imem[pc_cur[idx_w+1:2]];
   assign pc_plus4  = pc_cur + 32'd4;

   always_comb begin
      result = '0;
      take   = 1'b0;
      wr_en  = 1'b0;
      stop   = 1'b0;
      case (dec.kind)
         k_addi: begin
            result = rs1_val + dec.imm;
            wr_en  = 1'b1;
         end
         k_add: begin
            result = rs1_val + rs2_val;
            wr_en  = 1'b1;
         end
         k_sub: begin
            result = rs1_val - rs2_val;
            wr_en  = 1'b1;
         end
         k_lui: begin
            result = dec.imm;
            wr_en  = 1'b1;
         end
         k_beq: take = (rs1_val == rs2_val);
         k_bne: take = (rs1_val != rs2_val);
         k_jal: begin
            result = pc_plus4;
            wr_en  = 1'b1;
            take   = 1'b1;
            // jump to itself ends the program
            stop   = (dec.imm == '0);
         end
         default: stop = 1'b1;
      endcase
   end

   assign next_pc = take ? pc_cur + dec.imm : pc_plus4;

   always_ff @(posedge clk) begin
      if (rst) begin
         pc_q      <= '0;
         run_q     <= 1'b0;
         halted_q  <= 1'b0;
         illegal_q <= 1'b0;
      end else begin
         run_q <= run;
         if (exec) begin
            // an illegal word freezes pc where it sits
            pc_q      <= (dec.kind == k_illegal) ? pc_cur : next_pc;
            halted_q  <= stop;
            illegal_q <= (dec.kind == k_illegal);
         end
      end
   end

   reg_file u_reg_file (
      .clk      (clk),
      .rst      (rst),
      .rs1      (dec.rs1),
      .rs2      (dec.rs2),
      .rdata1   (rs1_val),
      .rdata2   (rs2_val),
      .we       (exec & wr_en),
      .waddr    (dec.rd),
      .wdata    (result),
      .dbg_idx  (dbg_idx),
      .dbg_data (dbg_data)
   );

endmodule

// ==== source/rv_isa_pkg.sv ====
package rv_isa_pkg;

   // data and register index widths
   localparam int xlen      = 32;
   localparam int reg_idx_w = 5;

   // instruction field widths
   localparam int opcode_w = 7;
   localparam int funct3_w = 3;
   localparam int funct7_w = 7;

   // major opcodes of the supported subset
   typedef enum logic [opcode_w-1:0] {
      op_imm = 7'b0010011,
      op_reg = 7'b0110011,
      lui    = 7'b0110111,
      branch = 7'b1100011,
      jal    = 7'b1101111
   } opcode_e;

   // decoded instruction kinds
   typedef enum logic [2:0] {
      k_addi,
      k_add,
      k_sub,
      k_lui,
      k_beq,
      k_bne,
      k_jal,
      k_illegal
   } instr_kind_e;

   // funct3 / funct7 values
   localparam logic [funct3_w-1:0] f3_add_sub = 3'b000;
   localparam logic [funct3_w-1:0] f3_beq     = 3'b000;
   localparam logic [funct3_w-1:0] f3_bne     = 3'b001;
   localparam logic [funct7_w-1:0] f7_base    = 7'b0000000;
   localparam logic [funct7_w-1:0] f7_sub     = 7'b0100000;

endpackage

// ==== source/tiny_rv_top.sv ====
`timescale 1ns/100ps

module tiny_rv_top
   import rv_isa_pkg::*;
   import apb_map_pkg::*;
   #(
   parameter int IMEM_DEPTH = 64
   )
   (
   input  logic                  clk,
   input  logic                  rst,
   input  logic                  psel,
   input  logic                  penable,
   input  logic                  pwrite,
   input  logic [apb_addr_w-1:0] paddr,
   input  logic [xlen-1:0]       pwdata,
   output logic [xlen-1:0]       prdata,
   output logic                  pready,
   output logic                  pslverr
   );

   localparam int idx_w = $clog2(IMEM_DEPTH);

   logic                 run;
   logic                 imem_we;
   logic [idx_w-1:0]     imem_idx;
   logic [xlen-1:0]      imem_wdata;
   logic [reg_idx_w-1:0] dbg_idx;
   logic [xlen-1:0]      dbg_data;
   logic [xlen-1:0]      pc;
   logic                 halted;
   logic                 illegal;
   logic [xlen-1:0]      instr_raw;

   decode_if dec_bus ();

   apb_debug_port #(
      .IMEM_DEPTH (IMEM_DEPTH)
   ) u_apb_debug_port (
      .clk        (clk),
      .rst        (rst),
      .psel       (psel),
      .penable    (penable),
      .pwrite     (pwrite),
      .paddr      (paddr),
      .pwdata     (pwdata),
      .prdata     (prdata),
      .pready     (pready),
      .pslverr    (pslverr),
      .run        (run),
      .imem_we    (imem_we),
      .imem_idx   (imem_idx),
      .imem_wdata (imem_wdata),
      .dbg_idx    (dbg_idx),
      .dbg_data   (dbg_data),
      .pc         (pc),
      .halted     (halted),
      .illegal    (illegal)
   );

   rv_core #(
      .IMEM_DEPTH (IMEM_DEPTH)
   ) u_rv_core (
      .clk        (clk),
      .rst        (rst),
      .run        (run),
      .imem_we    (imem_we),
      .imem_idx   (imem_idx),
      .imem_wdata (imem_wdata),
      .dbg_idx    (dbg_idx),
      .dbg_data   (dbg_data),
      .pc         (pc),
      .halted     (halted),
      .illegal    (illegal),
      .instr_raw  (instr_raw),
      .dec        (dec_bus.core_in)
   );

   decoder u_decoder (
      .instr_raw (instr_raw),
      .dec       (dec_bus.dec_out)
   );

endmodule

// ==== tb/tb_tiny_rv.sv ====
`timescale 1ns/100ps

module tb_tiny_rv
   import rv_isa_pkg::*;
   import apb_map_pkg::*;
   ();

   localparam int depth = 64;
   localparam int max_polls = 300;
   // six short programs with under 100 steps each, times the APB cost of loading,
   // polling and reading back, with a wide margin
   localparam int timeout_cycles = 20000;

   typedef logic [xlen-1:0] image_t [depth];
   typedef logic [xlen-1:0] regs_t [32];

   logic                  clk;
   logic                  rst;
   logic                  psel;
   logic                  penable;
   logic                  pwrite;
   logic [apb_addr_w-1:0] paddr;
   logic [xlen-1:0]       pwdata;
   logic [xlen-1:0]       prdata;
   logic                  pready;
   logic                  pslverr;

   image_t          prog_image;
   regs_t           model_regs;
   logic [xlen-1:0] model_pc;
   bit              model_ill;
   int              cycles = 0;

   tiny_rv_top #(
      .IMEM_DEPTH (depth)
   ) DUT (
      .clk     (clk),
      .rst     (rst),
      .psel    (psel),
      .penable (penable),
      .pwrite  (pwrite),
      .paddr   (paddr),
      .pwdata  (pwdata),
      .prdata  (prdata),
      .pready  (pready),
      .pslverr (pslverr)
   );

   tiny_rv_monitor mon (
      .clk     (clk),
      .rst     (rst),
      .psel    (psel),
      .penable (penable),
      .pwrite  (pwrite),
      .paddr   (paddr),
      .prdata  (prdata),
      .pslverr (pslverr)
   );

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (cycles >= timeout_cycles) begin
         $display("timeout: run stopped after %0d cycles", cycles);
         $display("=== FAIL ===");
         $finish;
      end
   end

   // instruction encoders
   function automatic logic [xlen-1:0] addi_word(input logic [4:0] rd, input logic [4:0] rs1,
                                                 input logic [11:0] imm);
      return {imm, rs1, 3'b000, rd, 7'b0010011};
   endfunction

   function automatic logic [xlen-1:0] r_type(input logic [6:0] f7, input logic [4:0] rd,
                                              input logic [4:0] rs1, input logic [4:0] rs2);
      return {f7, rs2, rs1, 3'b000, rd, 7'b0110011};
   endfunction

   function automatic logic [xlen-1:0] lui_word(input logic [4:0] rd, input logic [19:0] imm);
      return {imm, rd, 7'b0110111};
   endfunction

   function automatic logic [xlen-1:0] b_type(input logic [2:0] f3, input logic [4:0] rs1,
                                              input logic [4:0] rs2, input logic [12:0] off);
      return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
   endfunction

   function automatic logic [xlen-1:0] jal_word(input logic [4:0] rd, input logic [20:0] off);
      return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
   endfunction

   // illegal opcode 0x7f with the byte address in the upper bits
   function automatic logic [xlen-1:0] fill_word(input int idx);
      return {20'(idx * 4), 5'd0, 7'h7f};
   endfunction

   function automatic logic [apb_addr_w-1:0] reg_addr(input int r);
      return reg_base + 12'(r * 4);
   endfunction

   function automatic logic [apb_addr_w-1:0] imem_addr(input int i);
      return imem_base + 12'(i * 4);
   endfunction

   // instruction-set model of the subset that retires one instruction per step
   function automatic void ref_run(input image_t prog, input regs_t regs_in,
                                   output regs_t regs_out, output logic [xlen-1:0] pc_out,
                                   output bit ill_out);
      logic [xlen-1:0] w;
      logic [xlen-1:0] pc;
      logic [xlen-1:0] npc;
      logic [xlen-1:0] res;
      logic [xlen-1:0] a;
      logic [xlen-1:0] b;
      logic [xlen-1:0] off_b;
      logic [xlen-1:0] off_j;
      bit              wr;
      bit              done;
      int              steps;
      regs_out    = regs_in;
      regs_out[0] = '0;
      pc          = '0;
      ill_out     = 1'b0;
      done        = 1'b0;
      steps       = 0;
      while (!done && steps < 1000) begin
         w     = prog[pc[7:2]];
         a     = regs_out[w[19:15]];
         b     = regs_out[w[24:20]];
         off_b = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
         off_j = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
         wr    = 1'b0;
         res   = '0;
         npc   = pc + 32'd4;
         case (w[6:0])
            7'b0010011: begin
               wr  = (w[14:12] == 3'b000);
               res = a + {{20{w[31]}}, w[31:20]};
            end
            7'b0110011: begin
               wr  = (w[14:12] == 3'b000) && (w[31:25] == 7'h00 || w[31:25] == 7'h20);
               res = (w[31:25] == 7'h20) ? a - b : a + b;
            end
            7'b0110111: begin
               wr  = 1'b1;
               res = {w[31:12], 12'h000};
            end
            7'b1100011: begin
               if (w[14:12] == 3'b000 && a == b) npc = pc + off_b;
               if (w[14:12] == 3'b001 && a != b) npc = pc + off_b;
               if (w[14:12] > 3'b001) ill_out = 1'b1;
            end
            7'b1101111: begin
               wr   = 1'b1;
               res  = pc + 32'd4;
               npc  = pc + off_j;
               done = (off_j == '0);
            end
            default: ill_out = 1'b1;
         endcase
         // unsupported funct3/funct7 under a known opcode
         if (!wr && (w[6:0] == 7'b0010011 || w[6:0] == 7'b0110011)) ill_out = 1'b1;
         if (ill_out) begin
            wr   = 1'b0;
            npc  = pc;
            done = 1'b1;
         end
         if (wr && w[11:7] != 5'd0) regs_out[w[11:7]] = res;
         pc = npc;
         steps++;
      end
      pc_out = pc;
   endfunction

   task automatic apb_write(input logic [apb_addr_w-1:0] addr, input logic [xlen-1:0] data,
                            input bit err, input string name);
      mon.expect_transfer(1'b0, '0, err, name);
      @(posedge clk);
      psel    <= 1'b1;
      penable <= 1'b0;
      pwrite  <= 1'b1;
      paddr   <= addr;
      pwdata  <= data;
      @(posedge clk);
      penable <= 1'b1;
      @(posedge clk);
      psel    <= 1'b0;
      penable <= 1'b0;
      pwrite  <= 1'b0;
   endtask

   task automatic apb_read(input logic [apb_addr_w-1:0] addr, input bit check,
                           input logic [xlen-1:0] exp, input bit err, input string name,
                           output logic [xlen-1:0] data);
      mon.expect_transfer(check, exp, err, name);
      @(posedge clk);
      psel    <= 1'b1;
      penable <= 1'b0;
      pwrite  <= 1'b0;
      paddr   <= addr;
      @(posedge clk);
      penable <= 1'b1;
      @(negedge clk);
      data = prdata;
      @(posedge clk);
      psel    <= 1'b0;
      penable <= 1'b0;
   endtask

   task automatic fill_image();
      for (int i = 0; i < depth; i++) prog_image[i] = fill_word(i);
   endtask

   task automatic load_image();
      for (int i = 0; i < depth; i++) apb_write(imem_addr(i), prog_image[i], 1'b0, "imem");
   endtask

   task automatic wait_halted();
      logic [xlen-1:0] st;
      int              polls;
      st    = '0;
      polls = 0;
      while (st[status_halt_bit] !== 1'b1 && polls < max_polls) begin
         apb_read(addr_status, 1'b0, '0, 1'b0, "status poll", st);
         polls++;
      end
      if (st[status_halt_bit] !== 1'b1) begin
         mon.report_error($sformatf("core did not halt within %0d status polls", max_polls));
      end
   endtask

   task automatic check_state();
      logic [xlen-1:0] rd_val;
      logic [xlen-1:0] exp_status;
      exp_status                     = '0;
      exp_status[status_halt_bit]    = 1'b1;
      exp_status[status_illegal_bit] = model_ill;
      apb_read(addr_status, 1'b1, exp_status, 1'b0, "status", rd_val);
      apb_read(addr_pc, 1'b1, model_pc, 1'b0, "pc", rd_val);
      for (int r = 0; r < 32; r++) begin
         apb_read(reg_addr(r), 1'b1, model_regs[r], 1'b0, $sformatf("x%0d", r), rd_val);
      end
   endtask

   task automatic run_image();
      regs_t next_regs;
      ref_run(prog_image, model_regs, next_regs, model_pc, model_ill);
      model_regs = next_regs;
      apb_write(addr_ctrl, 32'd1, 1'b0, "ctrl");
      wait_halted();
      check_state();
      apb_write(addr_ctrl, 32'd0, 1'b0, "ctrl");
   endtask

   initial begin
      logic [xlen-1:0] rd_val;
      logic [4:0]      rd;
      logic [4:0]      rs1;
      logic [4:0]      rs2;
      int              op;
      int              n;
      rst     <= 1'b1;
      psel    <= 1'b0;
      penable <= 1'b0;
      pwrite  <= 1'b0;
      paddr   <= '0;
      pwdata  <= '0;
      for (int r = 0; r < 32; r++) model_regs[r] = '0;
      void'($urandom(49970));
      repeat (4) @(posedge clk);
      rst <= 1'b0;

      // reset values, ctrl readback, and a run into an illegal word at pc 0
      apb_read(addr_status, 1'b1, 32'd0, 1'b0, "status", rd_val);
      apb_read(addr_pc, 1'b1, 32'd0, 1'b0, "pc", rd_val);
      apb_read(addr_ctrl, 1'b1, 32'd0, 1'b0, "ctrl", rd_val);
      fill_image();
      load_image();
      apb_write(addr_ctrl, 32'd1, 1'b0, "ctrl");
      apb_read(addr_ctrl, 1'b1, 32'd1, 1'b0, "ctrl", rd_val);
      wait_halted();
      apb_read(addr_status, 1'b1, 32'd3, 1'b0, "status", rd_val);
      apb_read(addr_pc, 1'b1, 32'd0, 1'b0, "pc", rd_val);
      apb_write(addr_ctrl, 32'd0, 1'b0, "ctrl");
      apb_read(addr_ctrl, 1'b1, 32'd0, 1'b0, "ctrl", rd_val);
      mon.finish_test("reset and ctrl");

      // every register set first and then random arithmetic with some writes to x0
      fill_image();
      for (int r = 1; r < 32; r++) prog_image[r-1] = addi_word(5'(r), 5'd0, 12'($urandom));
      for (int k = 0; k < 24; k++) begin
         rd  = (k == 0) ? 5'd0 : 5'($urandom % 32);
         rs1 = 5'($urandom % 32);
         rs2 = 5'($urandom % 32);
         op  = $urandom % 4;
         case (op)
            0: prog_image[31+k] = addi_word(rd, rs1, 12'($urandom));
            1: prog_image[31+k] = r_type(7'h00, rd, rs1, rs2);
            2: prog_image[31+k] = r_type(7'h20, rd, rs1, rs2);
            default: prog_image[31+k] = lui_word(rd, 20'($urandom));
         endcase
      end
      prog_image[55] = jal_word(5'd0, 21'd0);
      load_image();
      run_image();
      mon.finish_test("arithmetic");

      // counting loop closed by a backward bne
      n = 3 + int'($urandom % 8);
      fill_image();
      prog_image[0]  = addi_word(5'd1, 5'd0, 12'd0);
      prog_image[1]  = addi_word(5'd2, 5'd0, 12'(n));
      prog_image[2]  = addi_word(5'd3, 5'd0, 12'd0);
      prog_image[3]  = addi_word(5'd1, 5'd1, 12'd1);
      prog_image[4]  = r_type(7'h00, 5'd3, 5'd3, 5'd1);
      prog_image[5]  = b_type(3'b001, 5'd1, 5'd2, -13'sd8);
      prog_image[6]  = b_type(3'b000, 5'd1, 5'd2, 13'd8);
      prog_image[7]  = addi_word(5'd4, 5'd0, 12'd99);
      prog_image[8]  = b_type(3'b000, 5'd1, 5'd0, 13'd8);
      prog_image[9]  = addi_word(5'd5, 5'd0, 12'd7);
      prog_image[10] = jal_word(5'd0, 21'd0);
      load_image();
      run_image();
      mon.finish_test("branches");

      // forward and backward jal with links run twice
      fill_image();
      prog_image[0] = jal_word(5'd1, 21'd16);
      prog_image[1] = addi_word(5'd11, 5'd13, 12'd1);
      prog_image[2] = jal_word(5'd12, 21'd0);
      prog_image[4] = addi_word(5'd13, 5'd0, 12'd3);
      prog_image[5] = jal_word(5'd14, -21'sd16);
      load_image();
      run_image();
      run_image();
      mon.finish_test("jumps");

      // slli is outside the subset
      fill_image();
      prog_image[0] = addi_word(5'd15, 5'd0, 12'd100);
      prog_image[1] = addi_word(5'd16, 5'd0, 12'hffb);
      prog_image[2] = {7'b0000000, 5'd1, 5'd1, 3'b001, 5'd1, 7'b0010011};
      prog_image[3] = addi_word(5'd17, 5'd0, 12'd1);
      load_image();
      run_image();
      mon.finish_test("illegal");

      // rejected accesses leave the state from the last run intact
      apb_write(reg_addr(5), 32'hdead_beef, 1'b1, "x5 write");
      apb_write(reg_addr(0), 32'h0000_0001, 1'b1, "x0 write");
      apb_read(imem_addr(0), 1'b0, '0, 1'b1, "imem read", rd_val);
      apb_read(12'h200, 1'b0, '0, 1'b1, "unmapped read", rd_val);
      apb_write(12'h300, 32'h1234_5678, 1'b1, "unmapped write");
      apb_write(addr_status, 32'd0, 1'b1, "status write");
      apb_write(addr_pc, 32'd4, 1'b1, "pc write");
      check_state();
      fill_image();
      prog_image[0] = jal_word(5'd0, 21'd0);
      load_image();
      run_image();
      apb_write(addr_ctrl, 32'd1, 1'b0, "ctrl");
      wait_halted();
      apb_write(imem_addr(0), addi_word(5'd1, 5'd0, 12'd5), 1'b1, "imem write while running");
      check_state();
      apb_write(addr_ctrl, 32'd0, 1'b0, "ctrl");
      run_image();
      mon.finish_test("bus errors");

      mon.print_counts();
      if (mon.fail_count == 0 && DUT.u_checker.fail_total == 0) begin
         $display("=== PASS ===");
      end else begin
         $display("=== FAIL ===");
      end
      $finish;
   end

endmodule

// ==== tb/tiny_rv_checker.sv ====
`timescale 1ns/100ps

module tiny_rv_checker
   import rv_isa_pkg::*;
   (
   input logic                 clk,
   input logic                 rst,
   input logic                 psel,
   input logic                 penable,
   input logic                 pready,
   input logic                 run,
   input logic                 halted,
   input logic [xlen-1:0]      pc,
   input logic [reg_idx_w-1:0] dbg_idx,
   input logic [xlen-1:0]      dbg_data
   );

   int fail_total = 0;

   x0_reads_zero: assert property (@(posedge clk) disable iff (rst)
      dbg_idx == '0 |-> dbg_data == '0)
      else begin
         $error("x0 read back as %h", dbg_data);
         fail_total++;
      end

   pc_aligned: assert property (@(posedge clk) disable iff (rst) pc[1:0] == 2'b00)
      else begin
         $error("pc %h is not word aligned", pc);
         fail_total++;
      end

   // a halted core keeps its pc until run is toggled
   pc_held: assert property (@(posedge clk) disable iff (rst)
      (run && halted) |=> pc == $past(pc))
      else begin
         $error("pc moved to %h while halted", pc);
         fail_total++;
      end

   no_wait_states: assert property (@(posedge clk) disable iff (rst)
      (psel && penable) |-> pready)
      else begin
         $error("pready low in an access phase");
         fail_total++;
      end

endmodule

bind tiny_rv_top tiny_rv_checker u_checker (
   .clk      (clk),
   .rst      (rst),
   .psel     (psel),
   .penable  (penable),
   .pready   (pready),
   .run      (run),
   .halted   (halted),
   .pc       (pc),
   .dbg_idx  (dbg_idx),
   .dbg_data (dbg_data)
);

// ==== tb/tiny_rv_monitor.sv ====
`timescale 1ns/100ps

module tiny_rv_monitor
   import rv_isa_pkg::*;
   import apb_map_pkg::*;
   (
   input logic                  clk,
   input logic                  rst,
   input logic                  psel,
   input logic                  penable,
   input logic                  pwrite,
   input logic [apb_addr_w-1:0] paddr,
   input logic [xlen-1:0]       prdata,
   input logic                  pslverr
   );

   int              pass_count = 0;
   int              fail_count = 0;
   int              test_checks = 0;
   int              test_fails = 0;
   bit              pending = 1'b0;
   bit              exp_check_data;
   logic [xlen-1:0] exp_data;
   bit              exp_err;
   string           exp_name;

   // the sequence announces each transfer before it starts
   task automatic expect_transfer(input bit check_data, input logic [xlen-1:0] data,
                                  input bit err, input string name);
      exp_check_data = check_data;
      exp_data       = data;
      exp_err        = err;
      exp_name       = name;
      pending        = 1'b1;
   endtask

   task automatic report_error(input string msg);
      $display("error: %s", msg);
      fail_count++;
      test_fails++;
   endtask

   task automatic finish_test(input string name);
      $display("test %s: %0d checks, %0d failed", name, test_checks, test_fails);
      test_checks = 0;
      test_fails  = 0;
   endtask

   task automatic print_counts();
      $display("checks: %0d passed, %0d failed", pass_count, fail_count);
   endtask

   // access phase values are stable at the falling edge
   always @(negedge clk) begin
      bit ok;
      ok = 1'b1;
      if (!rst && psel && penable) begin
         if (!pending) begin
            report_error($sformatf("APB transfer at address %h was not expected", paddr));
         end else begin
            if (pslverr !== exp_err) begin
               $display("FAILED %s pslverr (%s at %h): got %h, expected %h", exp_name,
                        pwrite ? "write" : "read", paddr, pslverr, exp_err);
               ok = 1'b0;
            end
            if (exp_check_data && prdata !== exp_data) begin
               $display("FAILED %s prdata (read at %h): got %h, expected %h", exp_name,
                        paddr, prdata, exp_data);
               ok = 1'b0;
            end
            test_checks++;
            if (ok) begin
               pass_count++;
            end else begin
               fail_count++;
               test_fails++;
            end
            pending = 1'b0;
         end
      end
   end

endmodule

// ==== tiny_rv.f ====
source/rv_isa_pkg.sv
source/apb_map_pkg.sv
source/decode_if.sv
source/decoder.sv
source/reg_file.sv
source/rv_core.sv
source/apb_debug_port.sv
source/tiny_rv_top.sv
tb/tiny_rv_checker.sv
tb/tiny_rv_monitor.sv
tb/tb_tiny_rv.sv
